// File: include/sat_alu_defs.svh
`ifndef SAT_ALU_DEFS_SVH
`define SAT_ALU_DEFS_SVH

// full datapath word
`define SAT_ALU_WIDTH 16

// one lane is also one lookahead block
`define SAT_ALU_LANE_W 4

// lanes per word for the nibble-parallel mode
`define SAT_ALU_LANES 4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, then run it; the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sat_alu.f --top-module sat_alu_tb -o sat_alu_sim \
    && ./obj_dir/sat_alu_sim \
    || exit 1

// File: sat_alu.f
+incdir+include
verilog/sat_alu_pkg.sv
verilog/cla_adder_4bit.sv
verilog/cla_adder_16bit.sv
verilog/saturate_unit.sv
verilog/sat_alu.sv
verif/sat_alu_props.sv
verif/sat_alu_tb.sv

// File: verif/sat_alu_props.sv
`timescale 1ns/1ns

module sat_alu_props
    import sat_alu_pkg::*;
(
    input logic     clk,
    input logic     arst_n,
    input logic     in_valid,
    input alu_req_t req_q,
    input logic     out_valid,
    input alu_rsp_t rsp
);

    // nothing leaves the pipeline while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high while arst_n is low");

    // two register stages between strobe and pulse
    valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two clock edges");

    xor_no_ovfl: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && $past(req_q.op) == OP_XOR) |-> !rsp.flags.v)
        else $error("v flag set on a xor result");

    // a zero word cannot be negative
    zero_not_neg: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && rsp.flags.z) |-> !rsp.flags.n)
        else $error("z and n flags set together");

endmodule

bind sat_alu sat_alu_props i_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .req_q     (req_q),
    .out_valid (out_valid),
    .rsp       (rsp)
);

// File: verif/sat_alu_tb.sv
`timescale 1ns/1ns
`include "sat_alu_defs.svh"

module sat_alu_tb
    import sat_alu_pkg::*;
();
    localparam int W           = `SAT_ALU_WIDTH;
    localparam int LW          = `SAT_ALU_LANE_W;
    localparam int WORD_HI     = (1 << (W-1)) - 1;
    localparam int WORD_LO     = -(1 << (W-1));
    localparam int LANE_HI     = (1 << (LW-1)) - 1;
    localparam int LANE_LO     = -(1 << (LW-1));
    localparam int SEED        = 15;
    localparam int N_DIRECTED  = 12;
    localparam int N_RANDOM    = 400;
    localparam int TOTAL_REQS  = N_DIRECTED + N_RANDOM;
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = (TOTAL_REQS * 4 + 100) * CLK_NS;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    alu_req_t req;
    logic     out_valid;
    alu_rsp_t rsp;

    alu_rsp_t exp_q[$];    // expected responses in request order
    string    name_q[$];
    alu_rsp_t exp_rsp;
    string    exp_name;
    int       n_checked;

    sat_alu i_sat_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    always #(CLK_NS/2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic int word_to_int(input word_t w);
        int v;
        v = int'(w);
        if (w[W-1]) v = v - (1 << W);   // two's complement
        return v;
    endfunction

    function automatic int lane_to_int(input lane_t l);
        int v;
        v = int'(l);
        if (l[LW-1]) v = v - (1 << LW);
        return v;
    endfunction

    // expected response straight from the opcode rules
    function automatic alu_rsp_t model_alu(input alu_req_t r);
        alu_rsp_t m;
        int       s;
        m = '0;
        case (r.op)
            OP_ADD, OP_SUB: begin
                if (r.op == OP_ADD) s = word_to_int(r.a) + word_to_int(r.b);
                else s = word_to_int(r.a) - word_to_int(r.b);
                if (s > WORD_HI) begin
                    s = WORD_HI;
                    m.flags.v = 1'b1;
                end else if (s < WORD_LO) begin
                    s = WORD_LO;
                    m.flags.v = 1'b1;
                end
                m.result = word_t'(s);
            end
            OP_PADDSB: begin
                for (int i = 0; i < `SAT_ALU_LANES; i++) begin
                    s = lane_to_int(r.a[i*LW +: LW]) + lane_to_int(r.b[i*LW +: LW]);
                    if (s > LANE_HI) begin
                        s = LANE_HI;
                        m.flags.v = 1'b1;   // any lane overflow counts
                    end else if (s < LANE_LO) begin
                        s = LANE_LO;
                        m.flags.v = 1'b1;
                    end
                    m.result[i*LW +: LW] = lane_t'(s);
                end
            end
            default: m.result = r.a ^ r.b;
        endcase
        m.flags.z = (m.result == '0);
        m.flags.n = m.result[W-1];
        return m;
    endfunction

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch %s result: expected %h actual %h",
                                        name, exp, act));
        end
    endtask

    task automatic compare_flags(input string name, input alu_flags_t exp,
                                 input alu_flags_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Mismatch %s flags znv: expected %b actual %b",
                                        name, exp, act));
        end
    endtask

    function automatic alu_req_t make_req(input alu_op_e op, input word_t a, input word_t b);
        alu_req_t r;
        r.op = op;
        r.a  = a;
        r.b  = b;
        return r;
    endfunction

    // corner values show up often so saturation gets exercised
    function automatic word_t random_operand();
        case ($urandom_range(0, 7))
            0: return 16'h7fff;
            1: return 16'h8000;
            2: return 16'h0000;
            3: return 16'hffff;
            default: return word_t'($urandom);
        endcase
    endfunction

    function automatic alu_req_t random_req();
        logic [1:0] op_bits;
        op_bits = 2'($urandom_range(0, 3));
        return make_req(alu_op_e'(op_bits), random_operand(), random_operand());
    endfunction

    task automatic send_req(input string name, input alu_req_t r);
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= r;
        exp_q.push_back(model_alu(r));
        name_q.push_back(name);
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // compare on the falling edge while the outputs are stable
    always @(negedge clk) begin
        if (!arst_n) begin
            if (out_valid !== 1'b0) stop_with_failure("out_valid not low during reset");
        end else if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("out_valid pulsed with no request outstanding");
            end else begin
                exp_rsp  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                compare_word(exp_name, exp_rsp.result, rsp.result);
                compare_flags(exp_name, exp_rsp.flags, rsp.flags);
                n_checked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog expired before all responses came back");
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        req       = '0;
        n_checked = 0;
        void'($urandom(SEED));

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        idle_cycles(5);   // quiet bus right after reset

        send_req("add_max_plus_one", make_req(OP_ADD, 16'h7fff, 16'h0001));
        send_req("add_min_plus_min", make_req(OP_ADD, 16'h8000, 16'h8000));
        send_req("add_to_zero", make_req(OP_ADD, 16'h0005, 16'hfffb));
        idle_cycles(1);
        send_req("sub_min_minus_one", make_req(OP_SUB, 16'h8000, 16'h0001));
        send_req("sub_zero_minus_min", make_req(OP_SUB, 16'h0000, 16'h8000));
        send_req("sub_exact", make_req(OP_SUB, 16'h1234, 16'h0234));
        send_req("sub_negative", make_req(OP_SUB, 16'h0003, 16'h0010));
        idle_cycles(2);
        // lanes 7+1, 8+8, 3+2, -1+1 from top to bottom
        send_req("paddsb_lanes", make_req(OP_PADDSB, 16'h783f, 16'h1821));
        send_req("paddsb_no_ovfl", make_req(OP_PADDSB, 16'h1234, 16'h2121));
        idle_cycles(1);
        send_req("xor_mixed", make_req(OP_XOR, 16'hf0f0, 16'h0ff0));
        send_req("xor_self", make_req(OP_XOR, 16'ha5a5, 16'ha5a5));
        send_req("xor_positive", make_req(OP_XOR, 16'h1234, 16'h0004));
        idle_cycles(3);

        for (int i = 0; i < N_RANDOM; i++) begin
            send_req($sformatf("random_%0d", i), random_req());
            if ($urandom_range(0, 3) == 0) idle_cycles($urandom_range(1, 2));
        end
        idle_cycles(1);

        // latency is fixed, so a short drain covers every request in flight
        repeat (6) @(negedge clk);
        if (exp_q.size() != 0 || n_checked != TOTAL_REQS) begin
            stop_with_failure($sformatf("%0d requests never got a response", exp_q.size()));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: verilog/cla_adder_16bit.sv
`timescale 1ns/1ns
`include "sat_alu_defs.svh"

module cla_adder_16bit
    import sat_alu_pkg::*;
(
    input  word_t                     a,
    input  word_t                     b,
    input  logic                      cin,
    input  logic                      split,       // four independent lanes
    output word_t                     sum,
    output logic [`SAT_ALU_LANES-1:0] lane_ovfl
);
    logic [`SAT_ALU_LANES-1:0] blk_prop;
    logic [`SAT_ALU_LANES-1:0] blk_gen;
    logic [`SAT_ALU_LANES-1:0] la_carry;   // lookahead carry into each block
    logic [`SAT_ALU_LANES-1:0] blk_cin;

    // second-level lookahead over the block group signals
    assign la_carry[0] = cin;
    assign la_carry[1] = blk_gen[0] | (blk_prop[0] & cin);
    assign la_carry[2] = blk_gen[1] |
                         (blk_prop[1] & blk_gen[0]) |
                         (blk_prop[1] & blk_prop[0] & cin);
    assign la_carry[3] = blk_gen[2] |
                         (blk_prop[2] & blk_gen[1]) |
                         (blk_prop[2] & blk_prop[1] & blk_gen[0]) |
                         (blk_prop[2] & blk_prop[1] & blk_prop[0] & cin);

    // lane mode cuts every carry between blocks
    assign blk_cin = split ? '0 : la_carry;

    for (genvar i = 0; i < `SAT_ALU_LANES; i++) begin : g_blk
        cla_adder_4bit i_blk (
            .a          (a[i*`SAT_ALU_LANE_W +: `SAT_ALU_LANE_W]),
            .b          (b[i*`SAT_ALU_LANE_W +: `SAT_ALU_LANE_W]),
            .cin        (blk_cin[i]),
            .sum        (sum[i*`SAT_ALU_LANE_W +: `SAT_ALU_LANE_W]),
            .prop_group (blk_prop[i]),
            .gen_group  (blk_gen[i]),
            .ovfl       (lane_ovfl[i])
        );
    end

endmodule

// File: verilog/cla_adder_4bit.sv
`timescale 1ns/1ns

module cla_adder_4bit
    import sat_alu_pkg::*;
(
    input  lane_t a,
    input  lane_t b,
    input  logic  cin,
    output lane_t sum,
    output logic  prop_group,
    output logic  gen_group,
    output logic  ovfl
);
    lane_t      prop;
    lane_t      gen;
    logic [4:0] carry;   // carry[i] goes into bit i

    assign prop = a ^ b;
    assign gen  = a & b;

    // every carry is flattened so none waits on the one below it
    assign carry[0] = cin;
    assign carry[1] = gen[0] | (prop[0] & cin);
    assign carry[2] = gen[1] | (prop[1] & gen[0]) | (prop[1] & prop[0] & cin);
    assign carry[3] = gen[2] |
                      (prop[2] & gen[1]) |
                      (prop[2] & prop[1] & gen[0]) |
                      (prop[2] & prop[1] & prop[0] & cin);

    assign prop_group = &prop;
    assign gen_group  = gen[3] |
                        (prop[3] & gen[2]) |
                        (prop[3] & prop[2] & gen[1]) |
                        (prop[3] & prop[2] & prop[1] & gen[0]);

    // block carry out from the group terms
    assign carry[4] = gen_group | (prop_group & cin);

    assign sum = prop ^ carry[3:0];

    // signed overflow when the carry into the msb differs from the carry out
    assign ovfl = carry[3] ^ carry[4];

endmodule

// File: verilog/sat_alu.sv
`timescale 1ns/1ns
`include "sat_alu_defs.svh"

module sat_alu
    import sat_alu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  alu_req_t req,
    output logic     out_valid,
    output alu_rsp_t rsp
);
    logic                      req_valid_q;
    alu_req_t                  req_q;

    word_t                     op_b;        // b after optional inversion
    logic                      add_cin;
    logic                      split;
    word_t                     add_sum;
    logic [`SAT_ALU_LANES-1:0] lane_ovfl;
    word_t                     sat_result;
    logic                      sat_ovfl;
    logic                      is_xor;
    alu_rsp_t                  rsp_d;

    // request stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= req;
        end
    end

    // subtract is a + ~b + 1
    assign add_cin = (req_q.op == OP_SUB);
    assign op_b    = add_cin ? ~req_q.b : req_q.b;
    assign split   = (req_q.op == OP_PADDSB);
    assign is_xor  = (req_q.op == OP_XOR);

    cla_adder_16bit i_adder (
        .a         (req_q.a),
        .b         (op_b),
        .cin       (add_cin),
        .split     (split),
        .sum       (add_sum),
        .lane_ovfl (lane_ovfl)
    );

    saturate_unit i_sat (
        .sum       (add_sum),
        .lane_ovfl (lane_ovfl),
        .split     (split),
        .result    (sat_result),
        .ovfl      (sat_ovfl)
    );

    // result select and flags
    always_comb begin
        rsp_d.result  = is_xor ? (req_q.a ^ req_q.b) : sat_result;
        rsp_d.flags.z = (rsp_d.result == '0);
        rsp_d.flags.n = rsp_d.result[`SAT_ALU_WIDTH-1];
        rsp_d.flags.v = sat_ovfl & ~is_xor;   // xor never saturates
    end

    // response stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= req_valid_q;
            if (req_valid_q) begin
                rsp <= rsp_d;   // holds the last response between pulses
            end
        end
    end

endmodule

// File: verilog/sat_alu_pkg.sv
`include "sat_alu_defs.svh"

package sat_alu_pkg;

    typedef logic [`SAT_ALU_WIDTH-1:0]  word_t;
    typedef logic [`SAT_ALU_LANE_W-1:0] lane_t;

    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,   // signed saturating add
        OP_SUB    = 2'd1,   // signed saturating subtract
        OP_PADDSB = 2'd2,   // per-lane saturating add
        OP_XOR    = 2'd3
    } alu_op_e;

    // 34 bit request
    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
    } alu_req_t;

    typedef struct packed {
        logic z;   // result is zero
        logic n;   // result top bit
        logic v;   // saturation happened
    } alu_flags_t;

    // 19 bit response
    typedef struct packed {
        word_t      result;
        alu_flags_t flags;
    } alu_rsp_t;

endpackage

// File: verilog/saturate_unit.sv
`timescale 1ns/1ns
`include "sat_alu_defs.svh"

module saturate_unit
    import sat_alu_pkg::*;
(
    input  word_t                     sum,
    input  logic [`SAT_ALU_LANES-1:0] lane_ovfl,
    input  logic                      split,
    output word_t                     result,
    output logic                      ovfl
);
    localparam word_t WORD_MAX = {1'b0, {(`SAT_ALU_WIDTH-1){1'b1}}};    // 0x7fff
    localparam word_t WORD_MIN = {1'b1, {(`SAT_ALU_WIDTH-1){1'b0}}};    // 0x8000
    localparam lane_t LANE_MAX = {1'b0, {(`SAT_ALU_LANE_W-1){1'b1}}};   // 0x7
    localparam lane_t LANE_MIN = {1'b1, {(`SAT_ALU_LANE_W-1){1'b0}}};   // 0x8

    // an overflowed sum has the wrong sign, so the clamp follows its inverse
    always_comb begin
        result = sum;
        if (split) begin
            for (int i = 0; i < `SAT_ALU_LANES; i++) begin
                if (lane_ovfl[i]) begin
                    result[i*`SAT_ALU_LANE_W +: `SAT_ALU_LANE_W] =
                        sum[(i+1)*`SAT_ALU_LANE_W-1] ? LANE_MAX : LANE_MIN;
                end
            end
        end else if (lane_ovfl[`SAT_ALU_LANES-1]) begin
            result = sum[`SAT_ALU_WIDTH-1] ? WORD_MAX : WORD_MIN;   // only the top lane counts
        end
    end

    assign ovfl = split ? |lane_ovfl : lane_ovfl[`SAT_ALU_LANES-1];

endmodule
